// File: Makefile
# Verilator build and run of the shared-memory testbench

TOP       ?= tb_mem_share_top
FILELIST  ?= mem_share_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the simulation and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "overridable: TOP FILELIST OBJ_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            load,
  input  logic [mem_share_pkg::BEAT_W-1:0] count,
  input  logic                            step,
  output logic                            last
);
  import mem_share_pkg::*;

  logic [BEAT_W-1:0] remaining;               // accesses left after the current one

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= count;
    end else if (step && (remaining != '0)) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign last = (remaining == '0);

endmodule

// File: cmd_select.sv
`timescale 1ns/1ps

module cmd_select (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [mem_share_pkg::NUM_REQ-1:0]                    grant,
  input  mem_share_pkg::mem_cmd_u [mem_share_pkg::NUM_REQ-1:0] cmd,
  input  logic                                                 capture,
  input  logic                                                 advance,
  output logic                                                 op,
  output logic [mem_share_pkg::ADDR_W-1:0]                     addr,
  output logic [mem_share_pkg::DATA_W-1:0]                     wdata,
  output logic [mem_share_pkg::BEAT_W-1:0]                     beats,
  output logic [mem_share_pkg::NUM_REQ-1:0]                    owner
);
  import mem_share_pkg::*;

  mem_cmd_u sel_cmd;
  mem_cmd_u cmd_q;

  always_comb begin
    sel_cmd = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (grant[i]) sel_cmd = cmd[i];         // grant is one-hot so at most one hit
    end
  end

  // op and beats are needed in the capture cycle to size the transfer
  assign op    = sel_cmd.wr.op;
  assign beats = sel_cmd.rd.beats;
  assign wdata = cmd_q.wr.data;

  always_ff @(posedge clk) begin
    if (capture) cmd_q <= sel_cmd;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner <= '0;
      addr  <= '0;
    end else if (capture) begin
      owner <= grant;
      addr  <= sel_cmd.wr.addr;
    end else if (advance) begin
      addr  <= addr + 1'b1;                   // 63 rolls over to 0
    end
  end

endmodule

// File: mem_share_pkg.sv
package mem_share_pkg;

  localparam int NUM_REQ = 4;                  // requesters sharing the memory
  localparam int ADDR_W  = 6;                  // 64 words
  localparam int DATA_W  = 16;
  localparam int BEAT_W  = 4;                  // a read moves beats + 1 words
  localparam int PAD_W   = DATA_W - BEAT_W;    // read view filler so both views line up

  // last-grant pointer after reset sits on the top requester so requester 0 wins first
  localparam logic [NUM_REQ-1:0] INIT_GRANT = {1'b1, {(NUM_REQ-1){1'b0}}};

  localparam logic OP_WRITE = 1'b0;
  localparam logic OP_READ  = 1'b1;

  localparam logic ST_IDLE = 1'b0;             // waiting for a grant
  localparam logic ST_XFER = 1'b1;             // one access per cycle

  // 23-bit command word, op and addr sit at the same place in both views
  typedef union packed {
    struct packed {
      logic              op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
    } wr;
    struct packed {
      logic              op;
      logic [ADDR_W-1:0] addr;
      logic [PAD_W-1:0]  pad;
      logic [BEAT_W-1:0] beats;
    } rd;
  } mem_cmd_u;

endpackage

// File: mem_share_sva.sv
`timescale 1ns/1ps

module mem_share_sva (
  input logic                              clk,
  input logic                              rst_n,
  input logic [mem_share_pkg::NUM_REQ-1:0] grant,
  input logic [mem_share_pkg::NUM_REQ-1:0] done,
  input logic                              rd_valid
);

  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant))
    else $error("grant has more than one bit set");

  // the owner keeps the memory until its done strobe
  grant_held: assert property (@(posedge clk) disable iff (!rst_n)
    (grant != '0) && ((done & grant) == '0) |=> grant == $past(grant))
    else $error("grant changed before the owner's done");

  done_owner: assert property (@(posedge clk) disable iff (!rst_n)
    (done == '0) || (done == grant))
    else $error("done does not match the current grant");

  rd_valid_granted: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid |-> $past(grant) != '0)    // read data always trails an access under a grant
    else $error("rd_valid without a granted access before it");

endmodule

bind mem_share_top mem_share_sva mem_share_sva_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .grant    (grant),
  .done     (done),
  .rd_valid (rd_valid)
);

// File: mem_share_top.f
mem_share_pkg.sv
rr_arbiter.sv
cmd_select.sv
beat_counter.sv
xfer_fsm.sv
shared_mem.sv
mem_share_top.sv
mem_share_sva.sv
tb_mem_share_top.sv

// File: mem_share_top.sv
`timescale 1ns/1ps

module mem_share_top (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [mem_share_pkg::NUM_REQ-1:0]                    req,
  input  mem_share_pkg::mem_cmd_u [mem_share_pkg::NUM_REQ-1:0] cmd,
  output logic [mem_share_pkg::NUM_REQ-1:0]                    grant,
  output logic [mem_share_pkg::NUM_REQ-1:0]                    done,
  output logic                                                 rd_valid,
  output logic [mem_share_pkg::DATA_W-1:0]                     rd_data
);
  import mem_share_pkg::*;

  logic               op;
  logic [ADDR_W-1:0]  addr;
  logic [DATA_W-1:0]  wdata;
  logic [BEAT_W-1:0]  beats;
  logic [NUM_REQ-1:0] owner;
  logic               capture;
  logic [BEAT_W-1:0]  load_count;
  logic               step;
  logic               advance;
  logic               we;
  logic               re;
  logic               last;

  rr_arbiter rr_arbiter_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .free  (done),                            // a finished transfer releases its grant
    .grant (grant)
  );

  cmd_select cmd_select_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .grant   (grant),
    .cmd     (cmd),
    .capture (capture),
    .advance (advance),
    .op      (op),
    .addr    (addr),
    .wdata   (wdata),
    .beats   (beats),
    .owner   (owner)
  );

  beat_counter beat_counter_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (capture),
    .count (load_count),
    .step  (step),
    .last  (last)
  );

  xfer_fsm xfer_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant      (grant),
    .op         (op),
    .beats      (beats),
    .owner      (owner),
    .last       (last),
    .capture    (capture),
    .load_count (load_count),
    .step       (step),
    .advance    (advance),
    .we         (we),
    .re         (re),
    .done       (done)
  );

  shared_mem shared_mem_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .we       (we),
    .re       (re),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (rd_data),
    .rd_valid (rd_valid)
  );

endmodule

// File: rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [mem_share_pkg::NUM_REQ-1:0] req,
  input  logic [mem_share_pkg::NUM_REQ-1:0] free,
  output logic [mem_share_pkg::NUM_REQ-1:0] grant
);
  import mem_share_pkg::*;

  logic               busy;
  logic               grab;
  logic [NUM_REQ-1:0] last_grant;
  logic [NUM_REQ-1:0] next_grant;

  // lowest set bit of vec as a one-hot word
  function automatic logic [NUM_REQ-1:0] first_set(input logic [NUM_REQ-1:0] vec);
    logic [NUM_REQ-1:0] hot;
    hot = '0;
    for (int i = NUM_REQ - 1; i >= 0; i--) begin
      if (vec[i]) begin
        hot    = '0;
        hot[i] = 1'b1;
      end
    end
    return hot;
  endfunction

  // first request above the last granted index, searching upward with wrap
  function automatic logic [NUM_REQ-1:0] rotate_pick(
    input logic [NUM_REQ-1:0] last,
    input logic [NUM_REQ-1:0] request
  );
    logic [2*NUM_REQ-1:0] req_twice;
    logic [2*NUM_REQ-1:0] hot_twice;
    logic [NUM_REQ-1:0]   pick;
    req_twice = {request, request};
    hot_twice = '0;
    pick      = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (last[i]) begin
        hot_twice = {2{first_set(req_twice[i+1 +: NUM_REQ])}};  // search from index i+1
        pick      = hot_twice[NUM_REQ-1-i +: NUM_REQ];           // rotate back into place
      end
    end
    return pick;
  endfunction

  assign next_grant = rotate_pick(last_grant, req);
  assign grab       = !busy && (req != '0);

  // idle grants follow req in the same cycle, a busy grant is the held pointer
  assign grant = grab ? next_grant : (busy ? last_grant : '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if ((grant & free) != '0) begin
      busy <= 1'b0;                           // owner finished, reopen arbitration
    end else if (grab) begin
      busy <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_grant <= INIT_GRANT;
    end else if (grab) begin
      last_grant <= next_grant;
    end
  end

endmodule

// File: shared_mem.sv
`timescale 1ns/1ps

module shared_mem (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            we,
  input  logic                            re,
  input  logic [mem_share_pkg::ADDR_W-1:0] addr,
  input  logic [mem_share_pkg::DATA_W-1:0] wdata,
  output logic [mem_share_pkg::DATA_W-1:0] rdata,
  output logic                            rd_valid
);
  import mem_share_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // single port, a cycle carries either a write or a read
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end else if (re) begin
      rdata <= mem[addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= re && !we;                  // marks rdata one cycle after the read
    end
  end

endmodule

// File: tb_mem_share_top.sv
`timescale 1ns/1ps

module tb_mem_share_top;
  import mem_share_pkg::*;

  localparam int NUM_ENT = 30;
  localparam int TIMEOUT = 60;                // cycles allowed for any single wait

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic [NUM_REQ-1:0]     req;
  mem_cmd_u [NUM_REQ-1:0] cmd;
  mem_cmd_u [NUM_REQ-1:0] cmd_next;
  logic [NUM_REQ-1:0]     grant;
  logic [NUM_REQ-1:0]     done;
  logic                   rd_valid;
  logic [DATA_W-1:0]      rd_data;

  logic [NUM_REQ-1:0] ent_mask [NUM_ENT];     // requesters raised by each test
  logic [22:0]        ent_cmd [NUM_ENT][NUM_REQ];
  int                 ent_order [NUM_ENT][NUM_REQ];  // expected grant sequence, -1 ends it

  logic [DATA_W-1:0] model_mem [64];
  logic [DATA_W-1:0] exp_data_q [$];
  int                exp_cycle_q [$];
  integer            seed = 32'h3457de28;
  int                errors = 0;
  int                cycle_no = 0;

  mem_share_top mem_share_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .cmd      (cmd),
    .grant    (grant),
    .done     (done),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  always #5 clk = ~clk;

  function automatic logic [22:0] wr_cmd(input logic [5:0] addr, input logic [15:0] data);
    return {OP_WRITE, addr, data};
  endfunction

  function automatic logic [22:0] rd_cmd(input logic [5:0] addr, input logic [3:0] beats);
    return {OP_READ, addr, 12'h000, beats};
  endfunction

  function automatic logic [15:0] fill_word(input logic [5:0] a);
    return {a, 4'h9, ~a};
  endfunction

  // first requester above the last one granted, wrapping around
  function automatic int rr_pick(input int last, input logic [NUM_REQ-1:0] pend);
    for (int s = 1; s <= NUM_REQ; s++) begin
      if (pend[(last + s) % NUM_REQ]) return (last + s) % NUM_REQ;
    end
    return -1;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic set_row(input int e, input logic [3:0] mask,
                         input logic [22:0] c0, c1, c2, c3);
    ent_mask[e]   = mask;
    ent_cmd[e][0] = c0;
    ent_cmd[e][1] = c1;
    ent_cmd[e][2] = c2;
    ent_cmd[e][3] = c3;
  endtask

  task automatic build_table();
    int                 ptr;
    logic [NUM_REQ-1:0] pend;
    for (int e = 0; e < 16; e++) begin        // every address gets known data first
      ent_mask[e] = '1;
      for (int r = 0; r < NUM_REQ; r++) begin
        ent_cmd[e][r] = wr_cmd(6'(e * 4 + r), fill_word(6'(e * 4 + r)));
      end
    end
    set_row(16, 4'b1111, wr_cmd(61, 16'h1234), wr_cmd(62, 16'h5678),
            wr_cmd(63, 16'h9abc), wr_cmd(0, 16'hdef0));
    set_row(17, 4'b0010, '0, rd_cmd(60, 5), '0, '0);  // burst wraps past 63
    set_row(18, 4'b0101, rd_cmd(62, 15), '0, wr_cmd(10, 16'h0a0a), '0);
    set_row(19, 4'b1010, '0, rd_cmd(8, 3), '0, wr_cmd(63, 16'h7777));
    set_row(20, 4'b1001, wr_cmd(1, 16'h1111), '0, '0, rd_cmd(63, 2));
    set_row(21, 4'b0110, '0, wr_cmd(33, 16'h3333), rd_cmd(32, 1), '0);
    set_row(22, 4'b1111, rd_cmd(0, 0), rd_cmd(20, 4), rd_cmd(40, 7), rd_cmd(50, 15));
    for (int e = 23; e < NUM_ENT; e++) begin
      ent_mask[e] = 4'($random(seed));
      if (ent_mask[e] == '0) ent_mask[e] = 4'b1000;
      for (int r = 0; r < NUM_REQ; r++) begin
        ent_cmd[e][r] = ($random(seed) % 2 != 0) ?
                        rd_cmd(6'($random(seed)), 4'($random(seed))) :
                        wr_cmd(6'($random(seed)), 16'($random(seed)));
      end
    end
    ptr = NUM_REQ - 1;                        // requester 0 is first after reset
    for (int e = 0; e < NUM_ENT; e++) begin
      pend = ent_mask[e];
      for (int s = 0; s < NUM_REQ; s++) begin
        ent_order[e][s] = -1;
        if (pend != '0) begin
          ptr             = rr_pick(ptr, pend);
          ent_order[e][s] = ptr;
          pend[ptr]       = 1'b0;
        end
      end
    end
  endtask

  // one clock: drive on the rising edge, sample read data at the falling edge
  task automatic run_cycle(input logic [NUM_REQ-1:0] req_next);
    @(posedge clk);
    req <= req_next;
    cmd <= cmd_next;
    @(negedge clk);
    cycle_no++;
    if (rd_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("[ERROR] %0t: rd_valid with no read outstanding", $time);
        errors++;
      end else begin
        check_value(cycle_no, exp_cycle_q.pop_front(), "rd_valid cycle");
        check_value(32'(rd_data), 32'(exp_data_q.pop_front()), "rd_data");
      end
    end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle_no) begin
      check_value(32'(rd_valid), 32'd1, "rd_valid");
      void'(exp_cycle_q.pop_front());
      void'(exp_data_q.pop_front());
    end
  endtask

  task automatic run_entry(input int e);
    logic [NUM_REQ-1:0] req_cur;
    logic [22:0]        c;
    int                 o;
    int                 n;
    int                 cyc;
    for (int r = 0; r < NUM_REQ; r++) cmd_next[r] = ent_cmd[e][r];
    req_cur = ent_mask[e];
    run_cycle(4'(1 << ent_order[e][0]));     // the others rise under the first grant
    for (int s = 0; s < NUM_REQ && ent_order[e][s] >= 0; s++) begin
      o   = ent_order[e][s];
      cyc = 0;
      while (grant == '0 && cyc < TIMEOUT) begin
        run_cycle(req_cur);
        cyc++;
      end
      if (grant == '0) begin
        $display("Timeout: requester %0d never got a grant in test %0d", o, e);
        errors++;
        return;
      end
      check_value(32'(grant), 1 << o, "grant");
      c = ent_cmd[e][o];
      n = (c[22] == OP_READ) ? int'(c[3:0]) + 1 : 1;
      if (c[22] == OP_WRITE) begin
        model_mem[c[21:16]] = c[15:0];
      end else begin
        for (int j = 0; j < n; j++) begin
          exp_data_q.push_back(model_mem[c[21:16] + 6'(j)]);  // address wraps at 63
          exp_cycle_q.push_back(cycle_no + 2 + j);
        end
      end
      cyc = 0;
      while (done == '0 && cyc < TIMEOUT) begin
        run_cycle(req_cur);
        cyc++;
        check_value(32'(grant), 1 << o, "held grant");
      end
      if (done == '0) begin
        $display("Timeout: requester %0d never saw done in test %0d", o, e);
        errors++;
        return;
      end
      check_value(32'(done), 1 << o, "done");
      check_value(cyc, n, "cycles from grant to done");
      req_cur[o] = 1'b0;                      // owner drops its request after done
      run_cycle(req_cur);
      check_value(32'(done), 32'd0, "done after its pulse");
    end
  endtask

  initial begin
    int errs_before;
    rst_n    <= 1'b0;
    req      <= '0;
    cmd      <= '0;
    cmd_next  = '0;
    build_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value(32'(grant), 32'd0, "grant after reset");
    check_value(32'(done), 32'd0, "done after reset");
    check_value(32'(rd_valid), 32'd0, "rd_valid after reset");
    $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");
    for (int e = 0; e < NUM_ENT; e++) begin
      errs_before = errors;
      run_entry(e);
      $display("test %0d mask %b: %s", e, ent_mask[e], (errors == errs_before) ? "ok" : "mismatch");
    end
    check_value(exp_data_q.size(), 32'd0, "reads still outstanding");
    $display("%0d tests run, %0d errors", NUM_ENT + 1, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: xfer_fsm.sv
`timescale 1ns/1ps

module xfer_fsm (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [mem_share_pkg::NUM_REQ-1:0] grant,
  input  logic                             op,
  input  logic [mem_share_pkg::BEAT_W-1:0]  beats,
  input  logic [mem_share_pkg::NUM_REQ-1:0] owner,
  input  logic                             last,
  output logic                             capture,
  output logic [mem_share_pkg::BEAT_W-1:0]  load_count,
  output logic                             step,
  output logic                             advance,
  output logic                             we,
  output logic                             re,
  output logic [mem_share_pkg::NUM_REQ-1:0] done
);
  import mem_share_pkg::*;

  logic state;
  logic op_q;                                 // operation of the running transfer
  logic access;

  assign capture    = (state == ST_IDLE) && (grant != '0);
  assign load_count = (op == OP_READ) ? beats : '0;  // writes are a single access

  assign access  = (state == ST_XFER);
  assign step    = access;
  assign advance = access;
  assign we      = access && (op_q == OP_WRITE);
  assign re      = access && (op_q == OP_READ);

  // done doubles as the arbiter's free strobe
  assign done = (access && last) ? owner : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      op_q  <= OP_WRITE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (capture) begin
            state <= ST_XFER;
            op_q  <= op;
          end
        end
        ST_XFER: begin
          if (last) state <= ST_IDLE;         // final access of the transfer
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule
